/* design/st_pkg.sv */
`default_nettype none

package st_pkg;

	//////////////////////////////////////////////////
	// bus types
	//////////////////////////////////////////////////

	// 68000 word address, a0 never leaves the cpu
	typedef logic [23:1] word_addr_t;
	typedef logic [15:0] data_word_t;

	// mcu bus phase, four slots per 2 MHz period
	typedef logic [1:0] bus_cycle_t;

	//////////////////////////////////////////////////
	// configuration enums
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// host upload index
	typedef enum logic [1:0] {
		TGT_TOS256 = 2'd0,
		TGT_TOS192 = 2'd1,
		TGT_CART   = 2'd2,
		TGT_CLEAR  = 2'd3
	} upload_target_e;

	//////////////////////////////////////////////////
	// fixed addresses
	//////////////////////////////////////////////////

	// byte addresses shifted down to word addresses
	localparam word_addr_t TOS256_BASE = word_addr_t'(24'he00000 >> 1);
	localparam word_addr_t TOS192_BASE = word_addr_t'(24'hfc0000 >> 1);
	localparam word_addr_t CART_BASE   = word_addr_t'(24'hfa0000 >> 1);

	// a[23:18] of the viking frame buffer
	// $c00000 normally, $e80000 in steroids mode
	localparam logic [5:0] VIKING_PREFIX_LO = 6'b110000;
	localparam logic [5:0] VIKING_PREFIX_HI = 6'b111010;

endpackage

`default_nettype wire

/* design/upload_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module upload_loader import st_pkg::*; (
	input  wire            clk_32,
	input  wire            xsint,
	input  wire            download_i,
	input  upload_target_e upload_target_i,
	input  wire            upload_req_i,
	input  data_word_t     upload_data_i,
	input  wire            upload_issued_i,
	output logic           upload_ack_o,
	output logic           upload_pending_o,
	output word_addr_t     upload_addr_o,
	output data_word_t     upload_word_o,
	output logic           tos192k_o
);

	logic download_q;
	logic download_rise;
	logic word_take;
	word_addr_t base_addr;

	assign download_rise = download_i & ~download_q;

	// new word only when the previous handshake has fully closed
	assign word_take = upload_req_i & ~upload_pending_o & ~upload_ack_o;

	// start address per upload target
	always_comb begin
		case (upload_target_i)
			TGT_TOS256: base_addr = TOS256_BASE;
			TGT_TOS192: base_addr = TOS192_BASE;
			TGT_CART:   base_addr = CART_BASE;
			default:    base_addr = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// address, handshake, tos flag
	//////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			download_q       <= 1'b0;
			upload_addr_o    <= '0;
			upload_pending_o <= 1'b0;
			upload_ack_o     <= 1'b0;
			tos192k_o        <= 1'b0;
		end else begin
			download_q <= download_i;

			// address steps once per write that left the mux
			if (download_rise)
				upload_addr_o <= base_addr;
			else if (upload_issued_i)
				upload_addr_o <= upload_addr_o + 23'd1;

			if (word_take)
				upload_pending_o <= 1'b1;
			else if (upload_issued_i)
				upload_pending_o <= 1'b0;

			// ack follows the issue, drops once the host lets go of req
			if (upload_issued_i)
				upload_ack_o <= 1'b1;
			else if (!upload_req_i)
				upload_ack_o <= 1'b0;

			// address is valid from the clock after download rose
			// FC0000 and up means 192k tos, anything in E region is 256k
			if (download_q) begin
				if (upload_addr_o[23:18] == 6'b111111)
					tos192k_o <= 1'b1;
				else if (upload_addr_o[23:20] == 4'he)
					tos192k_o <= 1'b0;
			end
		end
	end

	// host sends big endian words, swap for the sdram
	always_ff @(posedge clk_32) begin
		if (word_take)
			upload_word_o <= {upload_data_i[7:0], upload_data_i[15:8]};
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// req still up on the clock the ack was raised
	a_ack_needs_req: assert property (@(posedge clk_32) disable iff (!xsint)
		$rose(upload_ack_o) |-> $past(upload_req_i));

	// next word offered only once the last handshake has closed
	a_no_word_while_busy: assert property (@(posedge clk_32) disable iff (!xsint)
		$rose(upload_req_i) |-> !upload_pending_o && !upload_ack_o);

endmodule

`default_nettype wire

/* design/viking_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module viking_detect import st_pkg::*; #(
	parameter int VIKING_PROBES = 256
) (
	input  wire        clk_32,
	input  wire        xsint,
	input  wire        mhz8_en_i,
	input  wire        as_n_i,
	input  word_addr_t mbus_a_i,
	input  mem_size_e  mem_size_i,
	input  wire        viking_en_i,
	input  wire        steroids_i,
	output logic       viking_enable_o,
	output logic       viking_active_o
);

	localparam int CW = $clog2(VIKING_PROBES);
	localparam logic [CW-1:0] CNT_MAX = CW'(VIKING_PROBES - 1);

	logic [CW-1:0] probe_cnt;
	logic          probe_full;
	logic          probe_hit;
	logic [5:0]    prefix;

	// above 8 MB the $c00000 window is plain ram
	assign viking_enable_o = (viking_en_i && mem_size_i != MEM_14M) || steroids_i;

	assign prefix = steroids_i ? VIKING_PREFIX_HI : VIKING_PREFIX_LO;

	// cpu touching the frame buffer, one count per 8 MHz slot
	assign probe_hit = mhz8_en_i & ~as_n_i & viking_enable_o &
		(mbus_a_i[23:18] == prefix);

	//////////////////////////////////////////////////
	// probe counter
	//////////////////////////////////////////////////

	// a driver probes many times, a memory test only a few
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			probe_cnt       <= '0;
			probe_full      <= 1'b0;
			viking_active_o <= 1'b0;
		end else begin
			if (probe_hit) begin
				if (probe_cnt != CNT_MAX)
					probe_cnt <= probe_cnt + CW'(1);
				else
					probe_full <= 1'b1;
			end
			// sticky until reset
			viking_active_o <= viking_active_o | probe_full;
		end
	end

endmodule

`default_nettype wire

/* design/ram_window.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_window import st_pkg::*; (
	input  word_addr_t ram_a_i,
	input  mem_size_e  mem_size_i,
	input  wire        viking_enable_i,
	input  wire        steroids_i,
	output logic       ram_en_o
);

	logic size_hit;
	logic viking_hit;

	//////////////////////////////////////////////////
	// installed st ram
	//////////////////////////////////////////////////

	always_comb begin
		case (mem_size_i)
			MEM_512K: size_hit = (ram_a_i[23:19] == 5'b00000);
			MEM_1M:   size_hit = (ram_a_i[23:20] == 4'b0000);
			MEM_2M:   size_hit = (ram_a_i[23:21] == 3'b000);
			MEM_4M:   size_hit = (ram_a_i[23:22] == 2'b00);
			MEM_8M:   size_hit = ~ram_a_i[23];
			// 14 MB stops short of the rom and io area at $e00000
			MEM_14M:  size_hit = ~(&ram_a_i[23:21]);
			default:  size_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// viking frame buffer
	//////////////////////////////////////////////////

	// 256k at $c00000, or 512k at $e80000 in steroids mode
	always_comb begin
		if (!viking_enable_i)
			viking_hit = 1'b0;
		else if (steroids_i)
			viking_hit = (ram_a_i[23:19] == VIKING_PREFIX_HI[5:1]);
		else
			viking_hit = (ram_a_i[23:18] == VIKING_PREFIX_LO);
	end

	assign ram_en_o = size_hit | viking_hit;

endmodule

`default_nettype wire

/* design/ram_slot_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_slot_mux import st_pkg::*; (
	input  wire        clk_32,
	input  wire        xsint,
	input  wire        mhz8_en_i,
	input  bus_cycle_t bus_cycle_i,
	input  wire        turbo_i,
	input  wire        ras_n_i,
	input  word_addr_t ram_a_i,
	input  wire        ram_we_n_i,
	input  wire        ram_uds_i,
	input  wire        ram_lds_i,
	input  data_word_t ram_din_i,
	input  wire        viking_read_i,
	input  word_addr_t viking_vaddr_i,
	input  wire        viking_active_i,
	input  wire        ram_en_i,
	input  wire        upload_pending_i,
	input  word_addr_t upload_addr_i,
	input  data_word_t upload_word_i,
	input  wire        rom2_n_i,
	input  word_addr_t mbus_a_i,
	input  wire        tos192k_i,
	output logic       sdram_req_o,
	output logic       sdram_we_o,
	output logic [1:0] sdram_ds_o,
	output word_addr_t sdram_addr_o,
	output data_word_t sdram_din_o,
	output logic       upload_issued_o,
	output word_addr_t rom_a_o
);

	logic cpu_slot, viking_slot;
	logic ras_n_q, ras_fall;
	logic take_upload, take_viking, take_chip;

	// turbo moves the cpu one slot later and viking into the last one
	assign cpu_slot    = (bus_cycle_i == 2'd1) || (bus_cycle_i == 2'd2 && turbo_i);
	assign viking_slot = (bus_cycle_i == 2'd2 && !turbo_i) || (bus_cycle_i == 2'd3 && turbo_i);

	// ras sampled on enable clocks only
	assign ras_fall = mhz8_en_i & ras_n_q & ~ras_n_i;

	// pending stays up one clock after issue, don't write twice
	assign take_upload = mhz8_en_i & cpu_slot & upload_pending_i & ~upload_issued_o;
	assign take_viking = mhz8_en_i & viking_slot & viking_active_i & viking_read_i;
	// zero address is a refresh cycle
	assign take_chip   = ras_fall & (|ram_a_i) & ram_en_i;

	//////////////////////////////////////////////////
	// request register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_q         <= 1'b1;
			sdram_req_o     <= 1'b0;
			upload_issued_o <= 1'b0;
		end else begin
			if (mhz8_en_i)
				ras_n_q <= ras_n_i;
			sdram_req_o     <= take_upload | take_viking | take_chip;
			upload_issued_o <= take_upload;
		end
	end

	// upload first, then viking, chipset last
	always_ff @(posedge clk_32) begin
		if (take_upload) begin
			sdram_we_o   <= 1'b1;
			sdram_ds_o   <= 2'b11;
			sdram_addr_o <= upload_addr_i;
			sdram_din_o  <= upload_word_i;
		end else if (take_viking) begin
			sdram_we_o   <= 1'b0;
			sdram_ds_o   <= 2'b11;
			sdram_addr_o <= viking_vaddr_i;
			sdram_din_o  <= ram_din_i;
		end else if (take_chip) begin
			sdram_we_o   <= ~ram_we_n_i;
			sdram_ds_o   <= {ram_uds_i, ram_lds_i};
			sdram_addr_o <= ram_a_i;
			sdram_din_o  <= ram_din_i;
		end
	end

	// rom2 is the 256k/192k tos window, moved to where the upload put it
	assign rom_a_o = rom2_n_i ? mbus_a_i :
		{(tos192k_i ? 6'b111111 : 6'b111000), mbus_a_i[17:1]};

	// the port carries the upload write, taken in a cpu slot
	a_upload_in_cpu_slot: assert property (@(posedge clk_32) disable iff (!xsint)
		upload_issued_o |-> sdram_we_o && $past(cpu_slot && mhz8_en_i));

endmodule

`default_nettype wire

/* design/st_mem_front.sv */
`timescale 1ns/1ps
`default_nettype none

module st_mem_front import st_pkg::*; #(
	parameter int VIKING_PROBES = 256
) (
	input  wire            clk_32,
	input  wire            xsint,
	// host upload
	input  wire            download_i,
	input  upload_target_e upload_target_i,
	input  wire            upload_req_i,
	input  data_word_t     upload_data_i,
	output logic           upload_ack_o,
	output logic           tos192k_o,
	// configuration
	input  mem_size_e      mem_size_i,
	input  wire            viking_en_i,
	input  wire            steroids_i,
	input  wire            turbo_i,
	// cpu and mcu bus
	input  wire            mhz8_en_i,
	input  bus_cycle_t     bus_cycle_i,
	input  wire            as_n_i,
	input  word_addr_t     mbus_a_i,
	input  wire            rom2_n_i,
	input  wire            ras_n_i,
	input  word_addr_t     ram_a_i,
	input  wire            ram_we_n_i,
	input  wire            ram_uds_i,
	input  wire            ram_lds_i,
	input  data_word_t     ram_din_i,
	// viking card
	input  wire            viking_read_i,
	input  word_addr_t     viking_vaddr_i,
	output logic           viking_active_o,
	// sdram side
	output logic           sdram_req_o,
	output logic           sdram_we_o,
	output logic [1:0]     sdram_ds_o,
	output word_addr_t     sdram_addr_o,
	output data_word_t     sdram_din_o,
	output word_addr_t     rom_a_o
);

	logic       upload_pending;
	word_addr_t upload_addr;
	data_word_t upload_word;
	logic       upload_issued;
	logic       viking_enable;
	logic       ram_en;

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	upload_loader u_loader (
		.clk_32           (clk_32),
		.xsint            (xsint),
		.download_i       (download_i),
		.upload_target_i  (upload_target_i),
		.upload_req_i     (upload_req_i),
		.upload_data_i    (upload_data_i),
		.upload_issued_i  (upload_issued),
		.upload_ack_o     (upload_ack_o),
		.upload_pending_o (upload_pending),
		.upload_addr_o    (upload_addr),
		.upload_word_o    (upload_word),
		.tos192k_o        (tos192k_o)
	);

	viking_detect #(
		.VIKING_PROBES (VIKING_PROBES)
	) u_viking (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.as_n_i          (as_n_i),
		.mbus_a_i        (mbus_a_i),
		.mem_size_i      (mem_size_i),
		.viking_en_i     (viking_en_i),
		.steroids_i      (steroids_i),
		.viking_enable_o (viking_enable),
		.viking_active_o (viking_active_o)
	);

	ram_window u_window (
		.ram_a_i         (ram_a_i),
		.mem_size_i      (mem_size_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids_i),
		.ram_en_o        (ram_en)
	);

	ram_slot_mux u_mux (
		.clk_32           (clk_32),
		.xsint            (xsint),
		.mhz8_en_i        (mhz8_en_i),
		.bus_cycle_i      (bus_cycle_i),
		.turbo_i          (turbo_i),
		.ras_n_i          (ras_n_i),
		.ram_a_i          (ram_a_i),
		.ram_we_n_i       (ram_we_n_i),
		.ram_uds_i        (ram_uds_i),
		.ram_lds_i        (ram_lds_i),
		.ram_din_i        (ram_din_i),
		.viking_read_i    (viking_read_i),
		.viking_vaddr_i   (viking_vaddr_i),
		.viking_active_i  (viking_active_o),
		.ram_en_i         (ram_en),
		.upload_pending_i (upload_pending),
		.upload_addr_i    (upload_addr),
		.upload_word_i    (upload_word),
		.rom2_n_i         (rom2_n_i),
		.mbus_a_i         (mbus_a_i),
		.tos192k_i        (tos192k_o),
		.sdram_req_o      (sdram_req_o),
		.sdram_we_o       (sdram_we_o),
		.sdram_ds_o       (sdram_ds_o),
		.sdram_addr_o     (sdram_addr_o),
		.sdram_din_o      (sdram_din_o),
		.upload_issued_o  (upload_issued),
		.rom_a_o          (rom_a_o)
	);

endmodule

`default_nettype wire

/* tb/tb_st_mem_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_st_mem_front import st_pkg::*; ();

	logic           clk_32;
	logic           xsint;
	logic           download_i;
	upload_target_e upload_target_i;
	logic           upload_req_i;
	data_word_t     upload_data_i;
	logic           upload_ack_o;
	logic           tos192k_o;
	mem_size_e      mem_size_i;
	logic           viking_en_i;
	logic           steroids_i;
	logic           turbo_i;
	logic           mhz8_en_i;
	bus_cycle_t     bus_cycle_i;
	logic           as_n_i;
	word_addr_t     mbus_a_i;
	logic           rom2_n_i;
	logic           ras_n_i;
	word_addr_t     ram_a_i;
	logic           ram_we_n_i;
	logic           ram_uds_i;
	logic           ram_lds_i;
	data_word_t     ram_din_i;
	logic           viking_read_i;
	word_addr_t     viking_vaddr_i;
	logic           viking_active_o;
	logic           sdram_req_o;
	logic           sdram_we_o;
	logic [1:0]     sdram_ds_o;
	word_addr_t     sdram_addr_o;
	data_word_t     sdram_din_o;
	word_addr_t     rom_a_o;

	// slot generator state
	logic [2:0]  phase;
	bus_cycle_t  prev_cycle;
	logic        prev_en;
	logic [31:0] rng;
	// op, arg, data, expected data, expected byte address
	logic [71:0] pat [0:63];

	st_mem_front #(
		.VIKING_PROBES (256)
	) dut (.*);

	initial begin
		clk_32 = 1'b0;
		forever #50 clk_32 = ~clk_32;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// window rule from the memory map, byte addresses
	function automatic logic window_hit(input word_addr_t a, input mem_size_e sz);
		logic [23:0] byte_a;
		logic [24:0] limit;
		logic        hit;
		byte_a = {a, 1'b0};
		case (sz)
			MEM_512K: limit = 25'h0080000;
			MEM_1M:   limit = 25'h0100000;
			MEM_2M:   limit = 25'h0200000;
			MEM_4M:   limit = 25'h0400000;
			MEM_8M:   limit = 25'h0800000;
			MEM_14M:  limit = 25'h0e00000;
			default:  limit = 25'h0000000;
		endcase
		hit = ({1'b0, byte_a} < limit);
		// steroids stays off here, so only the 256k window at $c00000
		if (viking_en_i && limit <= 25'h0800000 && byte_a >= 24'hc00000 &&
			byte_a < 24'hc40000)
			hit = 1'b1;
		// refresh never hits
		return hit && (a != '0);
	endfunction

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns: %s never happened", $time, what);
		stop_run();
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %b, got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input word_addr_t exp, input word_addr_t act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input data_word_t exp, input data_word_t act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	// falling edge, remember the slot just sampled, set up the next one
	task automatic clock_step();
		@(negedge clk_32);
		prev_cycle  = bus_cycle_i;
		prev_en     = mhz8_en_i;
		phase       = phase + 3'd1;
		bus_cycle_i = phase[2:1];
		mhz8_en_i   = ~phase[0];
	endtask

	// until the coming rising edge is an 8 MHz enable
	task automatic wait_enable(input string what);
		int n;
		n = 0;
		while (!mhz8_en_i) begin
			n++;
			if (n > 16)
				report_timeout(what);
			clock_step();
		end
	endtask

	//////////////////////////////////////////////////
	// upload and rom
	//////////////////////////////////////////////////

	task automatic begin_download(input logic [1:0] tgt);
		upload_target_i = upload_target_e'(tgt);
		download_i      = 1'b1;
		clock_step();
		clock_step();
	endtask

	task automatic end_download(input logic exp_flag);
		download_i = 1'b0;
		clock_step();
		check_bit("tos192k_o", exp_flag, tos192k_o);
	endtask

	task automatic upload_word(input data_word_t data, input data_word_t exp_word,
		input logic [23:0] exp_byte);
		int n;
		upload_data_i = data;
		upload_req_i  = 1'b1;
		n = 0;
		clock_step();
		while (!sdram_req_o) begin
			n++;
			if (n > 64)
				report_timeout("sdram write for an upload word");
			clock_step();
		end
		check_bit("sdram_we_o", 1'b1, sdram_we_o);
		check_bit("sdram_ds_o[1]", 1'b1, sdram_ds_o[1]);
		check_bit("sdram_ds_o[0]", 1'b1, sdram_ds_o[0]);
		check_addr("sdram_addr_o", exp_byte[23:1], sdram_addr_o);
		check_data("sdram_din_o", exp_word, sdram_din_o);
		check_bit("upload write in cpu slot", 1'b1, prev_en && prev_cycle == 2'd1);
		// ack one clock after the write, single request
		clock_step();
		check_bit("upload_ack_o", 1'b1, upload_ack_o);
		check_bit("sdram_req_o", 1'b0, sdram_req_o);
		upload_req_i = 1'b0;
		n = 0;
		clock_step();
		while (upload_ack_o) begin
			n++;
			if (n > 16)
				report_timeout("upload_ack_o dropping after req");
			check_bit("sdram_req_o", 1'b0, sdram_req_o);
			clock_step();
		end
	endtask

	// rom window lands on the upload base, low 17 bits pick the word
	task automatic rom_check(input logic [23:0] base, input int count);
		rom2_n_i = 1'b0;
		for (int i = 0; i < count; i++) begin
			rng      = xorshift(rng);
			mbus_a_i = rng[22:0];
			clock_step();
			check_addr("rom_a_o", base[23:1] | {6'b000000, mbus_a_i[17:1]}, rom_a_o);
		end
		// outside rom2 the address passes
		rom2_n_i = 1'b1;
		clock_step();
		check_addr("rom_a_o", mbus_a_i, rom_a_o);
	endtask

	//////////////////////////////////////////////////
	// chipset ras cycles
	//////////////////////////////////////////////////

	task automatic ras_cycle(input word_addr_t a, input logic exp);
		logic [31:0] r;
		rng = xorshift(rng);
		r   = rng;
		// ras high on one enable clock, low on the next
		wait_enable("enable clock before ras");
		clock_step();
		wait_enable("enable clock for ras fall");
		ras_n_i    = 1'b0;
		ram_a_i    = a;
		ram_we_n_i = r[0];
		ram_uds_i  = r[1];
		ram_lds_i  = r[2];
		ram_din_i  = r[31:16];
		clock_step();
		check_bit("sdram_req_o", exp, sdram_req_o);
		if (exp) begin
			check_addr("sdram_addr_o", a, sdram_addr_o);
			check_data("sdram_din_o", r[31:16], sdram_din_o);
			check_bit("sdram_we_o", ~r[0], sdram_we_o);
			check_bit("sdram_ds_o[1]", r[1], sdram_ds_o[1]);
			check_bit("sdram_ds_o[0]", r[2], sdram_ds_o[0]);
		end
		ras_n_i = 1'b1;
		// one clock wide
		clock_step();
		check_bit("sdram_req_o", 1'b0, sdram_req_o);
	endtask

	task automatic ras_sweep(input mem_size_e sz, input int count);
		word_addr_t a;
		mem_size_i = sz;
		for (int i = 0; i < count; i++) begin
			rng = xorshift(rng);
			// every eighth one aimed at the viking frame buffer
			if (i % 8 == 7)
				a = {6'b110000, rng[16:0]};
			else
				a = rng[22:0] >> rng[31:29];
			ras_cycle(a, window_hit(a, sz));
		end
	endtask

	task automatic refresh_cycles(input int count);
		for (int i = 0; i < count; i++)
			ras_cycle('0, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// viking
	//////////////////////////////////////////////////

	task automatic viking_probes(input int count, input logic exp, input logic [23:0] base);
		for (int i = 0; i < count; i++) begin
			wait_enable("enable clock for a probe");
			as_n_i   = 1'b0;
			mbus_a_i = base[23:1];
			clock_step();
			as_n_i = 1'b1;
		end
		// active one clock after the count saturates
		clock_step();
		check_bit("viking_active_o", exp, viking_active_o);
	endtask

	task automatic viking_reads(input int count, input logic [23:0] base);
		int         n;
		word_addr_t exp;
		viking_read_i = 1'b1;
		for (int i = 0; i < count; i++) begin
			exp            = base[23:1] + word_addr_t'(i);
			viking_vaddr_i = exp;
			n = 0;
			clock_step();
			while (!sdram_req_o) begin
				n++;
				if (n > 32)
					report_timeout("viking read request");
				clock_step();
			end
			check_bit("sdram_we_o", 1'b0, sdram_we_o);
			check_addr("sdram_addr_o", exp, sdram_addr_o);
			check_bit("viking read in viking slot", 1'b1, prev_en && prev_cycle == 2'd2);
		end
		viking_read_i = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// pattern runner
	//////////////////////////////////////////////////

	initial begin
		logic [71:0] e;
		int          idx;
		logic        done;

		xsint           = 1'b0;
		download_i      = 1'b0;
		upload_target_i = TGT_TOS256;
		upload_req_i    = 1'b0;
		upload_data_i   = '0;
		mem_size_i      = MEM_4M;
		viking_en_i     = 1'b1;
		steroids_i      = 1'b0;
		turbo_i         = 1'b0;
		as_n_i          = 1'b1;
		mbus_a_i        = '0;
		rom2_n_i        = 1'b1;
		ras_n_i         = 1'b1;
		ram_a_i         = '0;
		ram_we_n_i      = 1'b1;
		ram_uds_i       = 1'b0;
		ram_lds_i       = 1'b0;
		ram_din_i       = '0;
		viking_read_i   = 1'b0;
		viking_vaddr_i  = '0;
		phase           = 3'd0;
		prev_cycle      = 2'd0;
		prev_en         = 1'b0;
		bus_cycle_i     = 2'd0;
		mhz8_en_i       = 1'b1;
		rng             = 32'd19610;
		for (idx = 0; idx < 64; idx++)
			pat[idx] = '0;
		$readmemh("tb/st_mem_front_patterns.txt", pat);

		repeat (4) clock_step();
		check_bit("sdram_req_o", 1'b0, sdram_req_o);
		check_bit("upload_ack_o", 1'b0, upload_ack_o);
		check_bit("viking_active_o", 1'b0, viking_active_o);
		check_bit("tos192k_o", 1'b0, tos192k_o);
		xsint = 1'b1;
		clock_step();

		done = 1'b0;
		idx  = 0;
		while (!done && idx < 64) begin
			e = pat[idx];
			case (e[71:64])
				8'h00: done = 1'b1;
				8'h01: begin_download(e[57:56]);
				8'h02: upload_word(e[55:40], e[39:24], e[23:0]);
				8'h03: end_download(e[56]);
				8'h04: rom_check(e[23:0], int'(e[63:56]));
				8'h05: ras_sweep(mem_size_e'(e[58:56]), int'(e[55:40]));
				8'h06: refresh_cycles(int'(e[63:56]));
				8'h07: viking_probes(int'(e[55:40]), e[56], e[23:0]);
				8'h08: viking_reads(int'(e[63:56]), e[23:0]);
				default: begin
					$display("Unknown command %h in pattern entry %0d", e[71:64], idx);
					stop_run();
				end
			endcase
			idx++;
		end

		if (done) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Pattern file ended without an end command");
			stop_run();
		end
	end

endmodule

`default_nettype wire

/* tb/st_mem_front_patterns.txt */
// 18 hex digits: op(2) arg(2) data(4) expected data(4) expected byte address(6)
// op 01 download start, 02 word, 03 download end, 04 rom remap, 05 ras sweep, 06 refresh, 07 probes, 08 viking reads, 00 end
// tos256 upload, words land from e00000 byte swapped
010000000000000000
020012343412e00000
0200abcdcdabe00002
02000f1e1e0fe00004
020080010180e00006
030000000000000000
040c00000000e00000
// tos192 upload sets the flag, rom moves to fc0000
010100000000000000
020060000060fc0000
020000fefe00fc0002
02004e75754efc0004
030100000000000000
040c00000000fc0000
// cartridge upload leaves the flag alone
010200000000000000
02002a5a5a2afa0000
030100000000000000
// tos256 again clears it
010000000000000000
0200ffeeeeffe00000
030000000000000000
040800000000e00000
// ras sweeps, size in arg, cycle count in data
050500400000000000
050000400000000000
050100400000000000
050200400000000000
050300400000000000
050400400000000000
060800000000000000
// 255 probes keep viking off, the 256th turns it on, then reads
070000ff0000c00000
070100010000c00000
080600000000c00100
000000000000000000

/* project.f */
design/st_pkg.sv
design/upload_loader.sv
design/viking_detect.sv
design/ram_window.sv
design/ram_slot_mux.sv
design/st_mem_front.sv
tb/tb_st_mem_front.sv

/* run.sh */
#!/bin/sh
# compile and run the st_mem_front testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_st_mem_front -Mdir "$build_dir" -o sim_tb -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TEST FAIL" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
echo "simulation finished without failure"
exit 0
